// ==== design/decode_settings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

`define VADDR_WIDTH    32
`define REG_ADDR_WIDTH 5
`define ECAUSE_WIDTH   4

`define OPC_LUI        7'b0110111
`define OPC_AUIPC      7'b0010111
`define OPC_JAL        7'b1101111
`define OPC_JALR       7'b1100111
`define OPC_BRANCH     7'b1100011
`define OPC_LOAD       7'b0000011
`define OPC_STORE      7'b0100011
`define OPC_OP_IMM     7'b0010011
`define OPC_OP         7'b0110011
`define OPC_SYSTEM     7'b1110011

`define EXC_ILLEGAL    4'd2
`define EXC_BREAKPOINT 4'd3
`define EXC_ECALL_M    4'd11

`endif

// ==== design/decode_pkg.sv ====
`include "decode_settings.svh"

package decode_pkg;

  typedef logic [31:0]                  instr_t;
  typedef logic [`VADDR_WIDTH-1:0]      addr_t;
  typedef logic [`REG_ADDR_WIDTH-1:0]   reg_addr_t;
  typedef logic [31:0]                  imm_t;
  typedef logic [`ECAUSE_WIDTH-1:0]     ecause_t;
  typedef logic [2:0]                   funct3_t; // Also ALU and compare function

  // ALU operand source
  typedef enum logic [1:0] {
    SEL_REG = 2'd0,
    SEL_PC  = 2'd1,
    SEL_IMM = 2'd2
  } alu_sel_t;

  typedef enum logic [2:0] {
    IMM_NONE = 3'd0,
    IMM_I    = 3'd1,
    IMM_S    = 3'd2,
    IMM_B    = 3'd3,
    IMM_U    = 3'd4,
    IMM_J    = 3'd5
  } imm_fmt_t;

  typedef enum logic [1:0] {
    ST_ACCEPT   = 2'd0, // Waiting for fetch
    ST_HOLD     = 2'd1, // Issued, waiting for ROB
    ST_REDIRECT = 2'd2  // Branch out, waiting for branch_back
  } stage_state_t;

endpackage

// ==== design/instr_fields.sv ====
`timescale 1ns/1ns

module instr_fields (
  input  decode_pkg::instr_t    instr,
  input  decode_pkg::imm_fmt_t  imm_fmt,
  output logic [6:0]            opcode,
  output decode_pkg::funct3_t   funct3,
  output logic [6:0]            funct7,
  output decode_pkg::reg_addr_t rs1,
  output decode_pkg::reg_addr_t rs2,
  output decode_pkg::reg_addr_t rd,
  output decode_pkg::imm_t      imm
);

  decode_pkg::imm_t imm_i;
  decode_pkg::imm_t imm_s;
  decode_pkg::imm_t imm_b;
  decode_pkg::imm_t imm_u;
  decode_pkg::imm_t imm_j;

  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  // All formats sign extend from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (imm_fmt)
      decode_pkg::IMM_I: imm = imm_i;
      decode_pkg::IMM_S: imm = imm_s;
      decode_pkg::IMM_B: imm = imm_b;
      decode_pkg::IMM_U: imm = imm_u;
      decode_pkg::IMM_J: imm = imm_j;
      default:           imm = '0; // No immediate
    endcase
  end

endmodule

// ==== design/op_classifier.sv ====
`timescale 1ns/1ns
`include "decode_settings.svh"

module op_classifier (
  input  logic [6:0]            opcode,
  input  decode_pkg::funct3_t   funct3,
  input  logic [6:0]            funct7,
  input  decode_pkg::reg_addr_t rs1,
  input  decode_pkg::reg_addr_t rs2,
  input  decode_pkg::reg_addr_t rd,
  input  logic                  exception_in,
  input  decode_pkg::ecause_t   ecause_in,
  output decode_pkg::imm_fmt_t  imm_fmt,
  output logic                  uses_rs1,
  output logic                  uses_rs2,
  output logic                  uses_rd,
  output decode_pkg::funct3_t   alu_func,
  output logic                  alu_modifier,
  output decode_pkg::alu_sel_t  alu_sel_a,
  output decode_pkg::alu_sel_t  alu_sel_b,
  output decode_pkg::funct3_t   cmp_func,
  output logic                  branch,
  output logic                  jump,
  output logic                  is_alu,
  output logic                  load,
  output logic                  store,
  output logic [1:0]            ls_size,
  output logic                  load_signed,
  output logic                  exception_out,
  output decode_pkg::ecause_t   ecause_out
);

  logic illegal;
  logic env_fields_set;

  // ECALL and EBREAK require all other fields zero
  assign env_fields_set = (funct7 != 7'd0) || (rs1 != '0) || (rd != '0);

  assign cmp_func    = funct3;
  assign ls_size     = funct3[1:0];
  assign load_signed = !funct3[2];

  always_comb begin
    imm_fmt      = decode_pkg::IMM_NONE;
    uses_rs1     = 1'b0;
    uses_rs2     = 1'b0;
    uses_rd      = 1'b0;
    alu_func     = 3'b110; // OR of imm with itself passes LUI through
    alu_modifier = 1'b0;
    alu_sel_a    = decode_pkg::SEL_IMM;
    alu_sel_b    = decode_pkg::SEL_IMM;
    branch       = 1'b0;
    jump         = 1'b0;
    is_alu       = 1'b1;
    load         = 1'b0;
    store        = 1'b0;
    illegal      = 1'b0;
    ecause_out   = ecause_in;
    case (opcode)
      `OPC_LUI: begin
        imm_fmt = decode_pkg::IMM_U;
        uses_rd = 1'b1;
      end
      `OPC_AUIPC: begin
        imm_fmt   = decode_pkg::IMM_U;
        uses_rd   = 1'b1;
        alu_func  = 3'b000;
        alu_sel_a = decode_pkg::SEL_PC;
      end
      `OPC_JAL: begin
        imm_fmt   = decode_pkg::IMM_J;
        uses_rd   = 1'b1;
        alu_func  = 3'b000;
        alu_sel_a = decode_pkg::SEL_PC;
        branch    = 1'b1;
        jump      = 1'b1;
      end
      `OPC_JALR: begin
        imm_fmt   = decode_pkg::IMM_I;
        uses_rs1  = 1'b1;
        uses_rd   = 1'b1;
        alu_func  = 3'b000;
        alu_sel_a = decode_pkg::SEL_REG;
        branch    = 1'b1;
        jump      = 1'b1;
        illegal   = (funct3 != 3'b000);
      end
      `OPC_BRANCH: begin
        imm_fmt   = decode_pkg::IMM_B;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        alu_func  = 3'b000; // Target is pc plus offset
        alu_sel_a = decode_pkg::SEL_PC;
        branch    = 1'b1;
        illegal   = (funct3[2:1] == 2'b01);
      end
      `OPC_LOAD: begin
        imm_fmt   = decode_pkg::IMM_I;
        uses_rs1  = 1'b1;
        uses_rd   = 1'b1;
        alu_func  = 3'b000;
        alu_sel_a = decode_pkg::SEL_REG;
        is_alu    = 1'b0; // Address from AGU
        load      = 1'b1;
        illegal   = funct3[2] && (funct3[1:0] == 2'b11); // No LDU
      end
      `OPC_STORE: begin
        imm_fmt   = decode_pkg::IMM_S;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        alu_func  = 3'b000;
        alu_sel_a = decode_pkg::SEL_REG;
        is_alu    = 1'b0;
        store     = 1'b1;
        illegal   = funct3[2];
      end
      `OPC_OP_IMM: begin
        imm_fmt      = decode_pkg::IMM_I;
        uses_rs1     = 1'b1;
        uses_rd      = 1'b1;
        alu_func     = funct3;
        alu_modifier = (funct3 == 3'b101) && funct7[5]; // SRAI
        alu_sel_a    = decode_pkg::SEL_REG;
        // RV64 shamt is 6 bits, so funct7[0] is part of it
        illegal      = ((funct3 == 3'b001) && (funct7[6:1] != 6'd0)) ||
                       ((funct3 == 3'b101) && (funct7[6] || (funct7[4:1] != 4'd0)));
      end
      `OPC_OP: begin
        uses_rs1     = 1'b1;
        uses_rs2     = 1'b1;
        uses_rd      = 1'b1;
        alu_func     = funct3;
        alu_modifier = funct7[5]; // SUB or SRA
        alu_sel_a    = decode_pkg::SEL_REG;
        alu_sel_b    = decode_pkg::SEL_REG;
        illegal      = (funct7 != 7'd0) &&
                       ((funct7 != 7'b0100000) || ((funct3 != 3'b000) && (funct3 != 3'b101)));
      end
      `OPC_SYSTEM: begin
        is_alu = 1'b0;
        if ((funct3 == 3'b000) && (rs2[`REG_ADDR_WIDTH-1:1] == '0) && !env_fields_set) begin
          ecause_out = rs2[0] ? `EXC_BREAKPOINT : `EXC_ECALL_M;
        end else begin
          illegal = 1'b1; // CSR, MRET, WFI and bad fields
        end
      end
      default: begin
        is_alu  = 1'b0;
        illegal = 1'b1;
      end
    endcase
    if (illegal) begin
      ecause_out = `EXC_ILLEGAL;
    end
  end

  // Own exceptions win over the fetch one
  assign exception_out = exception_in || illegal || (opcode == `OPC_SYSTEM);

endmodule

// ==== design/issue_register.sv ====
`timescale 1ns/1ns

module issue_register (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  valid_in,
  input  logic                  ready_in,
  input  logic                  branch_back,
  input  logic                  trapped,
  input  decode_pkg::addr_t     pc,
  input  decode_pkg::addr_t     next_pc,
  input  logic                  uses_rs1,
  input  logic                  uses_rs2,
  input  logic                  uses_rd,
  input  decode_pkg::funct3_t   alu_func,
  input  logic                  alu_modifier,
  input  decode_pkg::alu_sel_t  alu_sel_a,
  input  decode_pkg::alu_sel_t  alu_sel_b,
  input  decode_pkg::funct3_t   cmp_func,
  input  logic                  branch,
  input  logic                  jump,
  input  logic                  is_alu,
  input  logic                  load,
  input  logic                  store,
  input  logic [1:0]            ls_size,
  input  logic                  load_signed,
  input  logic                  exception_out,
  input  decode_pkg::ecause_t   ecause_out,
  input  decode_pkg::reg_addr_t rs1,
  input  decode_pkg::reg_addr_t rs2,
  input  decode_pkg::reg_addr_t rd,
  input  decode_pkg::imm_t      imm,
  output logic                  valid_out,
  output logic                  ready_out,
  output decode_pkg::addr_t     pc_q,
  output decode_pkg::addr_t     next_pc_q,
  output logic                  uses_rs1_q,
  output logic                  uses_rs2_q,
  output logic                  uses_rd_q,
  output decode_pkg::funct3_t   alu_func_q,
  output logic                  alu_modifier_q,
  output decode_pkg::alu_sel_t  alu_sel_a_q,
  output decode_pkg::alu_sel_t  alu_sel_b_q,
  output decode_pkg::funct3_t   cmp_func_q,
  output logic                  branch_q,
  output logic                  jump_q,
  output logic                  is_alu_q,
  output logic                  load_q,
  output logic                  store_q,
  output logic [1:0]            ls_size_q,
  output logic                  load_signed_q,
  output logic                  exception_out_q,
  output decode_pkg::ecause_t   ecause_out_q,
  output decode_pkg::reg_addr_t rs1_q,
  output decode_pkg::reg_addr_t rs2_q,
  output decode_pkg::reg_addr_t rd_q,
  output decode_pkg::imm_t      imm_q
);

  decode_pkg::stage_state_t state;
  decode_pkg::stage_state_t state_next;
  logic                     accept;

  assign ready_out = (state == decode_pkg::ST_ACCEPT);
  assign valid_out = (state == decode_pkg::ST_HOLD);
  assign accept    = valid_in && ready_out;

  always_comb begin
    state_next = state;
    case (state)
      decode_pkg::ST_ACCEPT: begin
        if (accept) begin
          state_next = decode_pkg::ST_HOLD;
        end
      end
      decode_pkg::ST_HOLD: begin
        if (ready_in) begin
          // Wait for the core to resolve the target
          state_next = (branch_q || jump_q) ? decode_pkg::ST_REDIRECT : decode_pkg::ST_ACCEPT;
        end
      end
      decode_pkg::ST_REDIRECT: begin
        if (branch_back) begin
          state_next = decode_pkg::ST_ACCEPT;
        end
      end
      default: state_next = decode_pkg::ST_ACCEPT;
    endcase
    if (trapped) begin
      state_next = decode_pkg::ST_ACCEPT; // Flush drops anything pending
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= decode_pkg::ST_ACCEPT;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      pc_q            <= '0;
      next_pc_q       <= '0;
      uses_rs1_q      <= 1'b0;
      uses_rs2_q      <= 1'b0;
      uses_rd_q       <= 1'b0;
      alu_func_q      <= '0;
      alu_modifier_q  <= 1'b0;
      alu_sel_a_q     <= decode_pkg::SEL_REG;
      alu_sel_b_q     <= decode_pkg::SEL_REG;
      cmp_func_q      <= '0;
      branch_q        <= 1'b0;
      jump_q          <= 1'b0;
      is_alu_q        <= 1'b0;
      load_q          <= 1'b0;
      store_q         <= 1'b0;
      ls_size_q       <= 2'b00;
      load_signed_q   <= 1'b0;
      exception_out_q <= 1'b0;
      ecause_out_q    <= '0;
      rs1_q           <= '0;
      rs2_q           <= '0;
      rd_q            <= '0;
      imm_q           <= '0;
    end else if (accept) begin
      pc_q            <= pc;
      next_pc_q       <= next_pc;
      uses_rs1_q      <= uses_rs1;
      uses_rs2_q      <= uses_rs2;
      uses_rd_q       <= uses_rd;
      alu_func_q      <= alu_func;
      alu_modifier_q  <= alu_modifier;
      alu_sel_a_q     <= alu_sel_a;
      alu_sel_b_q     <= alu_sel_b;
      cmp_func_q      <= cmp_func;
      branch_q        <= branch;
      jump_q          <= jump;
      is_alu_q        <= is_alu;
      load_q          <= load;
      store_q         <= store;
      ls_size_q       <= ls_size;
      load_signed_q   <= load_signed;
      exception_out_q <= exception_out;
      ecause_out_q    <= ecause_out;
      rs1_q           <= rs1;
      rs2_q           <= rs2;
      rd_q            <= uses_rd ? rd : '0; // No writeback target
      imm_q           <= imm;
    end
  end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic                  clk,
  input  logic                  rstn,
  input  decode_pkg::instr_t    instr,
  input  decode_pkg::addr_t     pc,
  input  decode_pkg::addr_t     next_pc,
  input  logic                  valid_in,
  input  logic                  exception_in,
  input  decode_pkg::ecause_t   ecause_in,
  input  logic                  ready_in,
  input  logic                  branch_back,
  input  logic                  trapped,
  output logic                  ready_out,
  output logic                  valid_out,
  output decode_pkg::addr_t     pc_q,
  output decode_pkg::addr_t     next_pc_q,
  output logic                  uses_rs1_q,
  output logic                  uses_rs2_q,
  output logic                  uses_rd_q,
  output decode_pkg::funct3_t   alu_func_q,
  output logic                  alu_modifier_q,
  output decode_pkg::alu_sel_t  alu_sel_a_q,
  output decode_pkg::alu_sel_t  alu_sel_b_q,
  output decode_pkg::funct3_t   cmp_func_q,
  output logic                  branch_q,
  output logic                  jump_q,
  output logic                  is_alu_q,
  output logic                  load_q,
  output logic                  store_q,
  output logic [1:0]            ls_size_q,
  output logic                  load_signed_q,
  output logic                  exception_out_q,
  output decode_pkg::ecause_t   ecause_out_q,
  output decode_pkg::reg_addr_t rs1_q,
  output decode_pkg::reg_addr_t rs2_q,
  output decode_pkg::reg_addr_t rd_q,
  output decode_pkg::imm_t      imm_q
);

  // Fields to classifier
  logic [6:0]            opcode;
  decode_pkg::funct3_t   funct3;
  logic [6:0]            funct7;
  decode_pkg::reg_addr_t rs1;
  decode_pkg::reg_addr_t rs2;
  decode_pkg::reg_addr_t rd;
  decode_pkg::imm_t      imm;
  decode_pkg::imm_fmt_t  imm_fmt;

  // Classifier to issue register
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  uses_rd;
  decode_pkg::funct3_t   alu_func;
  logic                  alu_modifier;
  decode_pkg::alu_sel_t  alu_sel_a;
  decode_pkg::alu_sel_t  alu_sel_b;
  decode_pkg::funct3_t   cmp_func;
  logic                  branch;
  logic                  jump;
  logic                  is_alu;
  logic                  load;
  logic                  store;
  logic [1:0]            ls_size;
  logic                  load_signed;
  logic                  exception_out;
  decode_pkg::ecause_t   ecause_out;

  instr_fields instr_fields_inst (.*);

  op_classifier op_classifier_inst (.*);

  issue_register issue_register_inst (.*);

endmodule

// ==== tests/decode_assert.sv ====
`timescale 1ns/1ns

module decode_assert (
  input logic                  clk,
  input logic                  rstn,
  input logic                  valid_in,
  input logic                  ready_in,
  input logic                  branch_back,
  input logic                  trapped,
  input logic                  ready_out,
  input logic                  valid_out,
  input logic                  branch_q,
  input logic                  jump_q,
  input logic                  uses_rd_q,
  input decode_pkg::reg_addr_t rd_q,
  input decode_pkg::addr_t     pc_q,
  input decode_pkg::imm_t      imm_q
);

  accept_issues: assert property (@(posedge clk) disable iff (rstn)
    valid_in && ready_out && !trapped |=> valid_out)
    else begin
      $error("Accepted instruction was not issued");
      decode_tb.assert_errors++;
    end

  hold_stable: assert property (@(posedge clk) disable iff (rstn)
    valid_out && !ready_in && !trapped |=> valid_out && $stable(pc_q) && $stable(imm_q)
      && $stable(rd_q))
    else begin
      $error("Payload changed under back-pressure");
      decode_tb.assert_errors++;
    end

  // Plain instruction frees the stage right away
  consume_frees: assert property (@(posedge clk) disable iff (rstn)
    valid_out && ready_in && !trapped && !(branch_q || jump_q) |=> ready_out)
    else begin
      $error("ready_out did not return after a non-branch was consumed");
      decode_tb.assert_errors++;
    end

  redirect_holds: assert property (@(posedge clk) disable iff (rstn)
    !ready_out && !valid_out && !branch_back && !trapped |=> !ready_out)
    else begin
      $error("ready_out rose without branch_back");
      decode_tb.assert_errors++;
    end

  trap_flushes: assert property (@(posedge clk) disable iff (rstn)
    trapped |=> ready_out && !valid_out)
    else begin
      $error("Stage not flushed after trapped");
      decode_tb.assert_errors++;
    end

  rd_gated: assert property (@(posedge clk) disable iff (rstn)
    valid_out && !uses_rd_q |-> rd_q == '0)
    else begin
      $error("rd_q nonzero for an instruction without a destination");
      decode_tb.assert_errors++;
    end

endmodule

// ==== tests/decode_tb.sv ====
`timescale 1ns/1ns
`include "decode_settings.svh"

module decode_tb;

  // About 140 instructions of at most 9 cycles each, with margin
  localparam int MAX_CYCLES = 3000;

  localparam logic [31:0] BAD_LIST [18] = '{
    32'h00001067, 32'h00002063, 32'h00007083, 32'h00004023, // JALR, branch, LDU, store
    32'h80001013, 32'h20005013, 32'h02000033, 32'h40001033, // Shifts, OP funct7
    32'h30001073, 32'h30200073, 32'h10500073, 32'h0ff0000f, // CSRRW, MRET, WFI, FENCE
    32'h0010009b, 32'h0000003b, 32'h000000f3, 32'h00108073, // W forms, bad ECALL/EBREAK
    32'h00000073, 32'h00100073                              // ECALL, EBREAK
  };

  logic        clk;
  logic        rstn;
  logic [31:0] instr;
  logic [31:0] pc;
  logic [31:0] next_pc;
  logic        valid_in;
  logic        exception_in;
  logic [3:0]  ecause_in;
  logic        ready_in;
  logic        branch_back;
  logic        trapped;
  logic        ready_out;
  logic        valid_out;
  logic [31:0] pc_q;
  logic [31:0] next_pc_q;
  logic        uses_rs1_q;
  logic        uses_rs2_q;
  logic        uses_rd_q;
  logic [2:0]  alu_func_q;
  logic        alu_modifier_q;
  logic [1:0]  alu_sel_a_q;
  logic [1:0]  alu_sel_b_q;
  logic [2:0]  cmp_func_q;
  logic        branch_q;
  logic        jump_q;
  logic        is_alu_q;
  logic        load_q;
  logic        store_q;
  logic [1:0]  ls_size_q;
  logic        load_signed_q;
  logic        exception_out_q;
  logic [3:0]  ecause_out_q;
  logic [4:0]  rs1_q;
  logic [4:0]  rs2_q;
  logic [4:0]  rd_q;
  logic [31:0] imm_q;

  // Reference model results
  logic [31:0]          exp_ins;
  logic [31:0]          exp_pc;
  logic [31:0]          exp_imm;
  logic [4:0]           exp_rd;
  logic                 exp_urs1;
  logic                 exp_urs2;
  logic                 exp_urd;
  decode_pkg::alu_sel_t exp_sel_a;
  decode_pkg::alu_sel_t exp_sel_b;
  logic [2:0]           exp_func;
  logic                 exp_mod;
  logic                 exp_alu;
  logic                 exp_branch;
  logic                 exp_jump;
  logic                 exp_load;
  logic                 exp_store;
  logic                 exp_exc;
  logic [3:0]           exp_cause;
  logic                 exp_decoded; // Legal, controls are defined

  int mismatch_errors = 0;
  int other_errors = 0;
  int assert_errors = 0;
  int cycles = 0;
  int k;
  int n;

  decode_stage decode_stage_inst (.*);

  bind decode_stage decode_assert decode_assert_inst (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      mismatch_errors++;
    end
  endtask

  task automatic check(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Error at %0t ns: %s", $time, what);
      other_errors++;
    end
  endtask

  function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
    logic signed [31:0] s;
    s = v << (32 - bits);
    return s >>> (32 - bits);
  endfunction

  task automatic predict(input logic [31:0] ins, input logic exc, input logic [3:0] cause);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       bad;
    logic       sys;
    f3 = ins[14:12];
    f7 = ins[31:25];
    bad = 1'b0;
    sys = 1'b0;
    exp_ins = ins;
    exp_imm = '0;
    {exp_urs1, exp_urs2, exp_urd} = 3'b000;
    {exp_branch, exp_jump, exp_load, exp_store} = 4'b0000;
    exp_sel_a = decode_pkg::SEL_IMM;
    exp_sel_b = decode_pkg::SEL_IMM;
    exp_func = 3'b000; // ADD
    exp_mod = 1'b0;
    exp_alu = 1'b1;
    case (ins[6:0])
      `OPC_LUI: begin
        exp_imm = {ins[31:12], 12'h000};
        exp_urd = 1'b1;
        exp_func = 3'b110; // OR of imm with itself
      end
      `OPC_AUIPC: begin
        exp_imm = {ins[31:12], 12'h000};
        exp_urd = 1'b1;
        exp_sel_a = decode_pkg::SEL_PC;
      end
      `OPC_JAL: begin
        exp_imm = sext({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}, 21);
        exp_urd = 1'b1;
        exp_sel_a = decode_pkg::SEL_PC;
        {exp_branch, exp_jump} = 2'b11;
      end
      `OPC_JALR: begin
        exp_imm = sext(ins[31:20], 12);
        {exp_urs1, exp_urd} = 2'b11;
        exp_sel_a = decode_pkg::SEL_REG;
        {exp_branch, exp_jump} = 2'b11;
        bad = (f3 != 3'b000);
      end
      `OPC_BRANCH: begin
        exp_imm = sext({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}, 13);
        {exp_urs1, exp_urs2} = 2'b11;
        exp_sel_a = decode_pkg::SEL_PC;
        exp_branch = 1'b1;
        bad = (f3 == 3'b010) || (f3 == 3'b011);
      end
      `OPC_LOAD: begin
        exp_imm = sext(ins[31:20], 12);
        {exp_urs1, exp_urd} = 2'b11;
        exp_sel_a = decode_pkg::SEL_REG;
        exp_load = 1'b1;
        exp_alu = 1'b0;
        bad = (f3 == 3'b111);
      end
      `OPC_STORE: begin
        exp_imm = sext({ins[31:25], ins[11:7]}, 12);
        {exp_urs1, exp_urs2} = 2'b11;
        exp_sel_a = decode_pkg::SEL_REG;
        exp_store = 1'b1;
        exp_alu = 1'b0;
        bad = f3[2];
      end
      `OPC_OP_IMM: begin
        exp_imm = sext(ins[31:20], 12);
        {exp_urs1, exp_urd} = 2'b11;
        exp_sel_a = decode_pkg::SEL_REG;
        exp_func = f3;
        exp_mod = (f3 == 3'b101) && ins[30]; // SRAI
        bad = ((f3 == 3'b001) && (ins[31:26] != 6'd0)) ||
              ((f3 == 3'b101) && (ins[31:26] != 6'd0) && (ins[31:26] != 6'b010000));
      end
      `OPC_OP: begin
        {exp_urs1, exp_urs2, exp_urd} = 3'b111;
        exp_sel_a = decode_pkg::SEL_REG;
        exp_sel_b = decode_pkg::SEL_REG;
        exp_func = f3;
        exp_mod = ins[30]; // SUB or SRA
        bad = !((f7 == 7'd0) || ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101))));
      end
      `OPC_SYSTEM: begin
        sys = 1'b1;
        bad = (ins != 32'h00000073) && (ins != 32'h00100073);
      end
      default: bad = 1'b1;
    endcase
    exp_rd = exp_urd ? ins[11:7] : 5'd0;
    exp_exc = exc || bad || sys;
    if (bad) begin
      exp_cause = `EXC_ILLEGAL;
    end else if (sys) begin
      exp_cause = ins[20] ? `EXC_BREAKPOINT : `EXC_ECALL_M;
    end else begin
      exp_cause = cause;
    end
    exp_decoded = !bad && !sys;
  endtask

  task automatic check_payload();
    compare("pc_q", pc_q, exp_pc);
    compare("next_pc_q", next_pc_q, exp_pc + 32'd4);
    compare("rs1_q", rs1_q, exp_ins[19:15]);
    compare("rs2_q", rs2_q, exp_ins[24:20]);
    compare("rd_q", rd_q, exp_rd);
    compare("exception_out_q", exception_out_q, exp_exc);
    compare("ecause_out_q", ecause_out_q, exp_cause);
    if (exp_decoded) begin
      compare("imm_q", imm_q, exp_imm);
      compare("uses_rs1_q", uses_rs1_q, exp_urs1);
      compare("uses_rs2_q", uses_rs2_q, exp_urs2);
      compare("uses_rd_q", uses_rd_q, exp_urd);
      compare("alu_sel_a_q", alu_sel_a_q, exp_sel_a);
      compare("alu_sel_b_q", alu_sel_b_q, exp_sel_b);
      compare("alu_func_q", alu_func_q, exp_func);
      compare("alu_modifier_q", alu_modifier_q, exp_mod);
      compare("is_alu_q", is_alu_q, exp_alu);
      compare("branch_q", branch_q, exp_branch);
      compare("jump_q", jump_q, exp_jump);
      compare("load_q", load_q, exp_load);
      compare("store_q", store_q, exp_store);
      if (exp_branch && !exp_jump) begin
        compare("cmp_func_q", cmp_func_q, exp_ins[14:12]);
      end
      if (exp_load || exp_store) begin
        compare("ls_size_q", ls_size_q, exp_ins[13:12]);
      end
      if (exp_load) begin
        compare("load_signed_q", load_signed_q, !exp_ins[14]);
      end
    end
  endtask

  // Drive one instruction and return after the accepting edge
  task automatic accept_instr(input logic [31:0] ins, input logic exc, input logic [3:0] cause);
    logic taken;
    instr = ins;
    pc = exp_pc;
    next_pc = exp_pc + 32'd4;
    exception_in = exc;
    ecause_in = cause;
    valid_in = 1'b1;
    do begin
      taken = ready_out;
      next_cycle();
    end while (!taken);
    valid_in = 1'b0;
  endtask

  task automatic issue(input logic [31:0] ins, input logic exc, input logic [3:0] cause);
    int stall;
    exp_pc = {$urandom} & 32'hffff_fffc;
    predict(ins, exc, cause);
    accept_instr(ins, exc, cause);
    check(valid_out && !ready_out, "handshake did not change after accept");
    check_payload();
    stall = $urandom_range(0, 3);
    repeat (stall) begin
      next_cycle();
      check(valid_out && !ready_out, "valid_out not held under back-pressure");
      check_payload();
    end
    ready_in = 1'b1;
    next_cycle();
    ready_in = 1'b0;
    check(!valid_out, "valid_out still high after the consuming edge");
    if (exp_branch || exp_jump) begin
      stall = $urandom_range(1, 3);
      repeat (stall) begin
        check(!ready_out, "ready_out rose before branch_back");
        next_cycle();
      end
      branch_back = 1'b1;
      next_cycle();
      branch_back = 1'b0;
    end
    check(ready_out, "ready_out did not return after the instruction left");
  endtask

  function automatic logic [31:0] legal_instr(input int kind);
    logic [31:0] ins;
    ins = $urandom;
    case (kind)
      0: ins[6:0] = `OPC_LUI;
      1: ins[6:0] = `OPC_AUIPC;
      2: ins[6:0] = `OPC_JAL;
      3: begin
        ins[6:0] = `OPC_JALR;
        ins[14:12] = 3'b000;
      end
      4: begin
        ins[6:0] = `OPC_BRANCH;
        if (ins[14:13] == 2'b01) begin
          ins[13] = 1'b0;
        end
      end
      5: begin
        ins[6:0] = `OPC_LOAD;
        if (ins[14:12] == 3'b111) begin
          ins[14] = 1'b0; // LD instead of LDU
        end
      end
      6: begin
        ins[6:0] = `OPC_STORE;
        ins[14] = 1'b0;
      end
      7: begin
        ins[6:0] = `OPC_OP_IMM;
        if (ins[14:12] == 3'b001) begin
          ins[31:26] = 6'd0;
        end else if (ins[14:12] == 3'b101) begin
          ins[31:26] = {1'b0, ins[30], 4'b0000};
        end
      end
      default: begin
        ins[6:0] = `OPC_OP;
        if (ins[30] && ((ins[14:12] == 3'b000) || (ins[14:12] == 3'b101))) begin
          ins[31:25] = 7'b0100000;
        end else begin
          ins[31:25] = 7'd0;
        end
      end
    endcase
    return ins;
  endfunction

  task automatic trap_tests();
    exp_pc = 32'h0000_1000;
    accept_instr(32'h00208033, 1'b0, 4'd0); // add x0, x1, x2 held
    trapped = 1'b1;
    next_cycle();
    trapped = 1'b0;
    check(!valid_out && ready_out, "held instruction not flushed by trapped");
    accept_instr(32'h0080006f, 1'b0, 4'd0); // jal waits for redirect
    ready_in = 1'b1;
    next_cycle();
    ready_in = 1'b0;
    check(!ready_out, "ready_out high while waiting for branch_back");
    trapped = 1'b1;
    next_cycle();
    trapped = 1'b0;
    check(ready_out, "redirect wait not cleared by trapped");
    trapped = 1'b1;
    accept_instr(32'h00100093, 1'b0, 4'd0);
    trapped = 1'b0;
    repeat (3) begin
      check(!valid_out && ready_out, "instruction accepted during trapped was issued");
      next_cycle();
    end
  endtask

  initial begin
    void'($urandom(28695));
    clk = 1'b0;
    rstn = 1'b1;
    instr = '0;
    pc = '0;
    next_pc = '0;
    valid_in = 1'b0;
    exception_in = 1'b0;
    ecause_in = '0;
    ready_in = 1'b0;
    branch_back = 1'b0;
    trapped = 1'b0;
    repeat (5) begin
      @(posedge clk);
    end
    #1;
    rstn = 1'b0;
    check(!valid_out && ready_out, "wrong handshake state after reset");
    compare("pc_q", pc_q, 32'd0);
    compare("imm_q", imm_q, 32'd0);
    compare("exception_out_q", exception_out_q, 1'b0);

    for (k = 0; k < 9; k++) begin
      repeat (12) begin
        issue(legal_instr(k), 1'b0, 4'd0);
      end
    end
    for (n = 0; n < 18; n++) begin
      issue(BAD_LIST[n], n[0], 4'd1); // Odd entries also carry a fetch fault
    end
    repeat (12) begin
      k = $urandom_range(0, 8);
      n = $urandom_range(0, 15);
      issue(legal_instr(k), 1'b1, n[3:0]);
    end
    trap_tests();

    next_cycle();
    $display("Errors: %0d mismatches, %0d handshake errors, %0d assertion failures",
             mismatch_errors, other_errors, assert_errors);
    if (mismatch_errors + other_errors + assert_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+design
design/decode_pkg.sv
design/instr_fields.sv
design/op_classifier.sv
design/issue_register.sv
design/decode_stage.sv
tests/decode_assert.sv
tests/decode_tb.sv
